// ==== build.f ====
verilog/rtc_pkg.sv
verilog/rtc_regs.sv
verilog/rtc_counter.sv
verilog/rtc_pps.sv
verilog/rtc_top.sv
testbench/rtc_checker.sv
testbench/tb_rtc.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with verilator, run, then decide by searching the log
rm -f sim.log
verilator --binary --timing -Wno-fatal -f build.f --top-module tb_rtc -o sim_rtc \
    && ./obj_dir/sim_rtc > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "test failed" sim.log && exit 1
exit 0

// ==== testbench/rtc_checker.sv ====
`timescale 1ns/1ps

module rtc_checker import rtc_pkg::*; (
    input  logic                      up_clk,
    input  logic                      up_rstn,
    input  logic                      up_wreq,
    input  logic [rtc_addr_width-1:0] up_waddr,
    input  logic [31:0]               up_wdata,
    input  logic                      up_wack,
    input  logic                      up_rreq,
    input  logic [rtc_addr_width-1:0] up_raddr,
    input  logic [31:0]               up_rdata,
    input  logic                      up_rack,
    input  logic                      pps,
    input  rtc_time_t                 now,
    output int                        errors
);

    int err_count = 0;
    bit model_ok  = 1'b0;

    // register model
    logic [31:0]        m_scratch, m_set_sec, m_inc, m_rdata;
    logic [29:0]        m_set_nsec;
    logic signed [31:0] m_adj;
    bit                 m_set_q, m_adj_q, m_get_q, m_wack, m_rack;

    // time model, fraction kept hidden as in the DUT
    logic [31:0]        m_sec, m_prev_sec, m_snap_sec;
    longint             m_nsec;
    logic [29:0]        m_snap_nsec;
    logic [23:0]        m_frac;
    int                 m_pps_left;

    assign errors = err_count;

    task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] got);
        if (got !== exp) begin
            err_count++;
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, got);
        end
    endtask

    function automatic logic [31:0] read_value(input logic [rtc_addr_width-1:0] addr);
        case (addr)
            reg_scratch:  return m_scratch;
            reg_get_sec:  return m_snap_sec;
            reg_get_nsec: return {2'b00, m_snap_nsec};
            reg_set_sec:  return m_set_sec;
            reg_set_nsec: return {2'b00, m_set_nsec};
            reg_adj_nsec: return m_adj;
            reg_inc:      return m_inc;
            default:      return 32'd0;
        endcase
    endfunction

    // ======================================================================
    // one model step per rising edge, from the inputs seen before it
    // ======================================================================

    task automatic step_model();
        longint      ns;
        logic [24:0] fs;
        if (!up_rstn) begin
            {m_scratch, m_set_sec, m_inc, m_rdata, m_set_nsec, m_adj} = '0;
            {m_set_q, m_adj_q, m_get_q, m_wack, m_rack} = '0;
            {m_sec, m_prev_sec, m_snap_sec, m_snap_nsec, m_frac} = '0;
            m_nsec     = 0;
            m_pps_left = 0;
            model_ok   = 1'b1;
        end else begin
            // read mux sees contents from before this edge
            if (up_rreq) begin
                m_rdata = read_value(up_raddr);
            end
            // pps window, restarted by any new second
            if (m_sec != m_prev_sec) begin
                m_pps_left = pps_width_cycles;
            end else if (m_pps_left > 0) begin
                m_pps_left--;
            end
            m_prev_sec = m_sec;
            if (m_get_q) begin
                m_snap_sec  = m_sec;
                m_snap_nsec = m_nsec[29:0];
            end
            if (m_set_q) begin
                m_sec  = m_set_sec;
                m_nsec = longint'(m_set_nsec);
                m_frac = '0;
            end else begin
                fs = {1'b0, m_frac} + {1'b0, m_inc[23:0]};
                ns = m_nsec + longint'(m_inc[31:24]) + longint'(fs[24]);
                if (m_adj_q) begin
                    ns = ns + longint'(m_adj);
                end
                if (ns < 0) begin
                    ns    = ns + ns_per_sec;
                    m_sec = m_sec - 32'd1;
                end else if (ns >= ns_per_sec) begin
                    ns    = ns - ns_per_sec;
                    m_sec = m_sec + 32'd1;
                end
                m_nsec = ns;
                m_frac = fs[23:0];
            end
            if (up_wreq) begin
                case (up_waddr)
                    reg_scratch:  m_scratch  = up_wdata;
                    reg_set_sec:  m_set_sec  = up_wdata;
                    reg_set_nsec: m_set_nsec = up_wdata[29:0];
                    reg_adj_nsec: m_adj      = up_wdata;
                    reg_inc:      m_inc      = up_wdata;
                    default:      ;
                endcase
            end
            m_set_q = up_wreq && (up_waddr == reg_set) && up_wdata[0];
            m_adj_q = up_wreq && (up_waddr == reg_adj_nsec);
            m_get_q = up_wreq && (up_waddr == reg_get) && up_wdata[0];
            m_wack  = up_wreq;
            m_rack  = up_rreq;
        end
    endtask

    // outputs and inputs are both settled at the falling edge
    always @(negedge up_clk) begin
        if (model_ok) begin
            compare("up_wack", 64'(m_wack), 64'(up_wack));
            compare("up_rack", 64'(m_rack), 64'(up_rack));
            if (m_rack) begin
                compare("up_rdata", 64'(m_rdata), 64'(up_rdata));
            end
            compare("now.sec", 64'(m_sec), 64'(now.sec));
            compare("now.nsec", m_nsec, 64'(now.nsec));
            compare("pps", 64'(m_pps_left > 0), 64'(pps));
        end
        step_model();
    end

endmodule

// ==== testbench/tb_rtc.sv ====
`timescale 1ns/1ps

module tb_rtc import rtc_pkg::*; ();

    localparam int ack_limit = 10;

    logic                      up_clk;
    logic                      up_rstn;
    logic                      up_wreq;
    logic [rtc_addr_width-1:0] up_waddr;
    logic [31:0]               up_wdata;
    logic                      up_wack;
    logic                      up_rreq;
    logic [rtc_addr_width-1:0] up_raddr;
    logic [31:0]               up_rdata;
    logic                      up_rack;
    logic                      pps;
    rtc_time_t                 now;
    int                        errors;
    int                        timeouts = 0;

    rtc_top u_rtc_top (
        .up_clk(up_clk), .up_rstn(up_rstn),
        .up_wreq(up_wreq), .up_waddr(up_waddr), .up_wdata(up_wdata), .up_wack(up_wack),
        .up_rreq(up_rreq), .up_raddr(up_raddr), .up_rdata(up_rdata), .up_rack(up_rack),
        .pps(pps), .now(now)
    );

    rtc_checker u_rtc_checker (
        .up_clk(up_clk), .up_rstn(up_rstn),
        .up_wreq(up_wreq), .up_waddr(up_waddr), .up_wdata(up_wdata), .up_wack(up_wack),
        .up_rreq(up_rreq), .up_raddr(up_raddr), .up_rdata(up_rdata), .up_rack(up_rack),
        .pps(pps), .now(now), .errors(errors)
    );

    always #4 up_clk = ~up_clk;

    // ======================================================================
    // bus helpers, all driving 1 ns after the rising edge
    // ======================================================================

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge up_clk);
            #1;
        end
    endtask

    task automatic wait_ack(input bit is_read);
        int cycles;
        cycles = 0;
        while ((is_read ? up_rack : up_wack) !== 1'b1 && cycles < ack_limit) begin
            @(posedge up_clk);
            #1;
            cycles++;
        end
        if ((is_read ? up_rack : up_wack) !== 1'b1) begin
            timeouts++;
            $display("no acknowledge from the DUT within %0d cycles at %0t", ack_limit, $time);
        end
    endtask

    task automatic write_reg(input logic [rtc_addr_width-1:0] addr, input logic [31:0] data);
        up_wreq  = 1'b1;
        up_waddr = addr;
        up_wdata = data;
        @(posedge up_clk);
        #1;
        up_wreq = 1'b0;
        wait_ack(1'b0);
        idle($urandom_range(0, 2));
    endtask

    task automatic read_reg(input logic [rtc_addr_width-1:0] addr);
        up_rreq  = 1'b1;
        up_raddr = addr;
        @(posedge up_clk);
        #1;
        up_rreq = 1'b0;
        wait_ack(1'b1);
        idle($urandom_range(0, 2));
    endtask

    task automatic set_time(input logic [31:0] sec, input logic [31:0] nsec);
        write_reg(reg_set_sec, sec);
        write_reg(reg_set_nsec, nsec);
        write_reg(reg_set, 32'd1);
    endtask

    function automatic logic [31:0] rand_nsec();
        return $urandom_range(0, ns_per_sec - 1);
    endfunction

    // signed offset, magnitude below one second
    function automatic logic [31:0] rand_adj();
        int mag;
        mag = $urandom_range(0, ns_per_sec - 1);
        return ($urandom_range(0, 1) != 0) ? -mag : mag;
    endfunction

    // ======================================================================
    // test phases
    // ======================================================================

    task automatic run_register_map();
        int a;
        repeat (40) begin
            case ($urandom_range(0, 5))
                0:       write_reg(reg_scratch, $urandom());
                1:       write_reg(reg_set_sec, $urandom());
                2:       write_reg(reg_set_nsec, rand_nsec() | ($urandom_range(0, 3) << 30));
                3:       write_reg(reg_adj_nsec, rand_adj());
                4:       write_reg(reg_inc, $urandom());
                default: write_reg($urandom_range(24, (1 << rtc_addr_width) - 1), $urandom());
            endcase
        end
        for (a = 0; a < 32; a++) begin
            read_reg(a);
        end
        repeat (8) read_reg($urandom_range(32, (1 << rtc_addr_width) - 1));
    endtask

    task automatic run_increment();
        repeat (4) begin
            write_reg(reg_inc, {8'($urandom_range(1, 255)), 24'($urandom())});
            // start just below a second so the rollover comes soon
            set_time($urandom(), ns_per_sec - $urandom_range(1, 8000));
            idle(120);
        end
    endtask

    task automatic run_set_get();
        repeat (6) begin
            set_time($urandom(), rand_nsec());
            idle($urandom_range(0, 20));
            write_reg(reg_get, 32'd1);
            read_reg(reg_get_sec);
            read_reg(reg_get_nsec);
        end
        // bit 0 clear, snapshot must hold
        write_reg(reg_get, 32'd2);
        read_reg(reg_get_nsec);
    endtask

    task automatic run_adjust();
        int adj;
        repeat (24) begin
            case ($urandom_range(0, 3))
                0: adj = int'($urandom_range(0, 6)) - 3;
                1: begin
                    set_time($urandom(), $urandom_range(0, 500));
                    adj = -int'($urandom_range(1, 1000));
                end
                2: begin
                    set_time($urandom(), ns_per_sec - $urandom_range(1, 500));
                    adj = $urandom_range(0, 1000);
                end
                default: adj = rand_adj();
            endcase
            write_reg(reg_adj_nsec, adj);
            idle($urandom_range(0, 5));
        end
        // set and adjust back to back, both orders
        write_reg(reg_set_sec, $urandom());
        write_reg(reg_set_nsec, rand_nsec());
        write_reg(reg_adj_nsec, rand_adj());
        write_reg(reg_set, 32'd1);
        write_reg(reg_adj_nsec, rand_adj());
        idle(10);
    endtask

    task automatic run_pps();
        write_reg(reg_inc, 32'h0100_0000);
        set_time(32'd10, ns_per_sec - 40);
        idle(80);
        // second set lands mid-pulse
        set_time(32'd100, 32'd5);
        idle(2);
        set_time(32'd200, 32'd5);
        idle(40);
    endtask

    // ======================================================================
    // main sequence
    // ======================================================================

    initial begin
        up_clk   = 1'b0;
        up_rstn  = 1'b0;
        up_wreq  = 1'b0;
        up_waddr = '0;
        up_wdata = '0;
        up_rreq  = 1'b0;
        up_raddr = '0;
        void'($urandom(73));
        repeat (8) @(posedge up_clk);
        #1;
        up_rstn = 1'b1;

        // increment still zero, time must stand
        idle(20);
        write_reg(reg_scratch, $urandom());
        idle(10);

        run_register_map();
        run_increment();
        run_set_get();
        run_adjust();
        run_pps();
        idle(20);

        $display("checker errors %0d, timeouts %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== verilog/rtc_counter.sv ====
`timescale 1ns/1ps

module rtc_counter import rtc_pkg::*; (
    input  logic      up_clk,
    input  logic      up_rstn,
    input  rtc_ctrl_t ctrl,
    output rtc_time_t now,
    output rtc_time_t snap
);

    // sub-nanosecond part of the time, not visible to the host
    logic [23:0]        frac_q;

    // fraction accumulate
    logic [24:0]        frac_sum;
    logic               frac_carry;

    // signed nanosecond sum, wide enough for nsec + inc + adj
    logic signed [33:0] adj_ext;
    logic signed [33:0] nsec_sum;

    // normalized result
    logic signed [33:0] nsec_norm;
    logic [31:0]        sec_norm;

    // ======================================================================
    // next time
    // ======================================================================

    assign frac_sum   = {1'b0, frac_q} + {1'b0, ctrl.inc_frac};
    assign frac_carry = frac_sum[24];

    // adjust offset only counts in its strobe cycle
    assign adj_ext = ctrl.adj ? {{2{ctrl.adj_nsec[31]}}, ctrl.adj_nsec} : 34'sd0;

    assign nsec_sum = $signed({4'b0000, now.nsec})
                    + $signed({26'd0, ctrl.inc_nsec})
                    + $signed({33'd0, frac_carry})
                    + adj_ext;

    // at most one second of borrow or carry
    always_comb begin
        nsec_norm = nsec_sum;
        sec_norm  = now.sec;
        if (nsec_sum < 0) begin
            nsec_norm = nsec_sum + ns_per_sec;
            sec_norm  = now.sec - 32'd1;
        end else if (nsec_sum >= ns_per_sec) begin
            nsec_norm = nsec_sum - ns_per_sec;
            sec_norm  = now.sec + 32'd1;
        end
    end

    // ======================================================================
    // time register
    // ======================================================================

    // set overrides both the increment and any adjust
    always_ff @(posedge up_clk) begin
        if (!up_rstn) begin
            now    <= '0;
            frac_q <= '0;
        end else if (ctrl.set) begin
            now    <= ctrl.set_time;
            frac_q <= '0;
        end else begin
            now.sec  <= sec_norm;
            now.nsec <= nsec_norm[29:0];
            frac_q   <= frac_sum[23:0];
        end
    end

    // snapshot takes the time as it was before this edge
    always_ff @(posedge up_clk) begin
        if (!up_rstn) begin
            snap <= '0;
        end else if (ctrl.get) begin
            snap <= now;
        end
    end

endmodule

// ==== verilog/rtc_pkg.sv ====
package rtc_pkg;

    // ======================================================================
    // constants
    // ======================================================================

    // host address width, the address map is fixed
    localparam int rtc_addr_width = 14;

    // rollover limit of the nanosecond field
    localparam int ns_per_sec = 1_000_000_000;

    // pps pulse length in up_clk cycles
    localparam int pps_width_cycles = 16;
    localparam int pps_cnt_width = $clog2(pps_width_cycles);

    // ======================================================================
    // types
    // ======================================================================

    // time of day, nsec always kept below ns_per_sec
    typedef struct packed {
        logic [31:0] sec;
        logic [29:0] nsec;
    } rtc_time_t;

    // register file to counter
    typedef struct packed {
        logic               set;
        rtc_time_t          set_time;
        logic               adj;
        logic signed [31:0] adj_nsec;
        logic               get;
        logic [7:0]         inc_nsec;
        logic [23:0]        inc_frac;
    } rtc_ctrl_t;

    // host register map
    typedef enum logic [rtc_addr_width-1:0] {
        reg_scratch  = 14'd2,
        reg_get      = 14'd16,
        reg_get_sec  = 14'd17,
        reg_get_nsec = 14'd18,
        reg_set      = 14'd19,
        reg_set_sec  = 14'd20,
        reg_set_nsec = 14'd21,
        reg_adj_nsec = 14'd22,
        reg_inc      = 14'd23
    } rtc_reg_e;

    typedef enum logic {
        pps_idle,
        pps_high
    } pps_state_e;

endpackage

// ==== verilog/rtc_pps.sv ====
`timescale 1ns/1ps

module rtc_pps import rtc_pkg::*; (
    input  logic      up_clk,
    input  logic      up_rstn,
    input  rtc_time_t now,
    output logic      pps
);

    logic [31:0]              prev_sec;
    logic                     sec_change;
    pps_state_e               state;
    logic [pps_cnt_width-1:0] cnt;

    // ======================================================================
    // second boundary detect
    // ======================================================================

    // any change counts, increment, adjust or set alike
    always_ff @(posedge up_clk) begin
        if (!up_rstn) begin
            prev_sec <= '0;
        end else begin
            prev_sec <= now.sec;
        end
    end

    assign sec_change = (now.sec != prev_sec);

    // ======================================================================
    // pulse width FSM
    // ======================================================================

    always_ff @(posedge up_clk) begin
        if (!up_rstn) begin
            state <= pps_idle;
            cnt   <= '0;
        end else begin
            case (state)
                pps_idle: begin
                    if (sec_change) begin
                        state <= pps_high;
                        cnt   <= pps_cnt_width'(pps_width_cycles - 1);
                    end
                end
                pps_high: begin
                    // new second mid-pulse restarts the window
                    if (sec_change) begin
                        cnt <= pps_cnt_width'(pps_width_cycles - 1);
                    end else if (cnt == '0) begin
                        state <= pps_idle;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: begin
                    state <= pps_idle;
                end
            endcase
        end
    end

    assign pps = (state == pps_high);

endmodule

// ==== verilog/rtc_regs.sv ====
`timescale 1ns/1ps

module rtc_regs import rtc_pkg::*; (
    input  logic                      up_clk,
    input  logic                      up_rstn,

    // write channel
    input  logic                      up_wreq,
    input  logic [rtc_addr_width-1:0] up_waddr,
    input  logic [31:0]               up_wdata,
    output logic                      up_wack,

    // read channel
    input  logic                      up_rreq,
    input  logic [rtc_addr_width-1:0] up_raddr,
    output logic [31:0]               up_rdata,
    output logic                      up_rack,

    // counter side
    input  rtc_time_t                 snap,
    output rtc_ctrl_t                 ctrl
);

    // held host values
    logic [31:0]        scratch;
    rtc_time_t          set_time;
    logic signed [31:0] adj_nsec;
    logic [7:0]         inc_nsec;
    logic [23:0]        inc_frac;

    // one-cycle command strobes
    logic               set_q;
    logic               adj_q;
    logic               get_q;

    // ======================================================================
    // write decode
    // ======================================================================

    always_ff @(posedge up_clk) begin
        if (!up_rstn) begin
            scratch  <= '0;
            set_time <= '0;
            adj_nsec <= '0;
            inc_nsec <= '0;
            inc_frac <= '0;
        end else if (up_wreq) begin
            case (up_waddr)
                reg_scratch: begin
                    scratch <= up_wdata;
                end
                reg_set_sec: begin
                    set_time.sec <= up_wdata;
                end
                reg_set_nsec: begin
                    // top two bits dropped, nsec is 30 bits wide
                    set_time.nsec <= up_wdata[29:0];
                end
                reg_adj_nsec: begin
                    adj_nsec <= up_wdata;
                end
                reg_inc: begin
                    {inc_nsec, inc_frac} <= up_wdata;
                end
                default: begin
                    // unmapped or strobe-only address
                end
            endcase
        end
    end

    // set and get need bit 0, any adjust write fires
    always_ff @(posedge up_clk) begin
        if (!up_rstn) begin
            set_q <= 1'b0;
            adj_q <= 1'b0;
            get_q <= 1'b0;
        end else begin
            set_q <= up_wreq && (up_waddr == reg_set) && up_wdata[0];
            adj_q <= up_wreq && (up_waddr == reg_adj_nsec);
            get_q <= up_wreq && (up_waddr == reg_get) && up_wdata[0];
        end
    end

    // control bundle to the counter
    always_comb begin
        ctrl.set      = set_q;
        ctrl.set_time = set_time;
        ctrl.adj      = adj_q;
        ctrl.adj_nsec = adj_nsec;
        ctrl.get      = get_q;
        ctrl.inc_nsec = inc_nsec;
        ctrl.inc_frac = inc_frac;
    end

    // ======================================================================
    // read mux
    // ======================================================================

    always_ff @(posedge up_clk) begin
        if (!up_rstn) begin
            up_rdata <= '0;
        end else if (up_rreq) begin
            case (up_raddr)
                reg_scratch:  up_rdata <= scratch;
                reg_get_sec:  up_rdata <= snap.sec;
                reg_get_nsec: up_rdata <= {2'b00, snap.nsec};
                reg_set_sec:  up_rdata <= set_time.sec;
                reg_set_nsec: up_rdata <= {2'b00, set_time.nsec};
                reg_adj_nsec: up_rdata <= adj_nsec;
                reg_inc:      up_rdata <= {inc_nsec, inc_frac};
                default:      up_rdata <= '0;
            endcase
        end
    end

    // ======================================================================
    // acknowledges
    // ======================================================================

    // every request is answered the next cycle, mapped or not
    always_ff @(posedge up_clk) begin
        if (!up_rstn) begin
            up_wack <= 1'b0;
            up_rack <= 1'b0;
        end else begin
            up_wack <= up_wreq;
            up_rack <= up_rreq;
        end
    end

endmodule

// ==== verilog/rtc_top.sv ====
`timescale 1ns/1ps

module rtc_top import rtc_pkg::*; (
    input  logic                      up_clk,
    input  logic                      up_rstn,

    // host write channel
    input  logic                      up_wreq,
    input  logic [rtc_addr_width-1:0] up_waddr,
    input  logic [31:0]               up_wdata,
    output logic                      up_wack,

    // host read channel
    input  logic                      up_rreq,
    input  logic [rtc_addr_width-1:0] up_raddr,
    output logic [31:0]               up_rdata,
    output logic                      up_rack,

    // time outputs
    output logic                      pps,
    output rtc_time_t                 now
);

    rtc_ctrl_t ctrl;
    rtc_time_t snap;

    // ======================================================================
    // host registers
    // ======================================================================

    rtc_regs u_rtc_regs (
        .up_clk   (up_clk),
        .up_rstn  (up_rstn),
        .up_wreq  (up_wreq),
        .up_waddr (up_waddr),
        .up_wdata (up_wdata),
        .up_wack  (up_wack),
        .up_rreq  (up_rreq),
        .up_raddr (up_raddr),
        .up_rdata (up_rdata),
        .up_rack  (up_rack),
        .snap     (snap),
        .ctrl     (ctrl)
    );

    // ======================================================================
    // time of day and pulse
    // ======================================================================

    rtc_counter u_rtc_counter (
        .up_clk  (up_clk),
        .up_rstn (up_rstn),
        .ctrl    (ctrl),
        .now     (now),
        .snap    (snap)
    );

    rtc_pps u_rtc_pps (
        .up_clk  (up_clk),
        .up_rstn (up_rstn),
        .now     (now),
        .pps     (pps)
    );

endmodule
